/* project.f */
hdl/csc_pkg.sv
hdl/pair_sequencer.sv
hdl/csc_datapath.sv
hdl/rgb_packer.sv
hdl/csc_top.sv
test/csc_checker.sv
test/csc_asserts.sv
test/tb_csc.sv

/* Bender.yml */
package:
  name: csc

sources:
  - hdl/csc_pkg.sv
  - hdl/pair_sequencer.sv
  - hdl/csc_datapath.sv
  - hdl/rgb_packer.sv
  - hdl/csc_top.sv
  - target: test
    files:
      - test/csc_checker.sv
      - test/csc_asserts.sv
      - test/tb_csc.sv

/* test/tb_csc.sv */
// YUV to RGB converter testbench
`timescale 1ns/10ps

module tb_csc;

	import csc_pkg::*;

	localparam int DONE_TIMEOUT = NUM_PAIRS * 12 + 50; // Cycles from Start

	// Extreme pairs 0 to 3, pair 0 in the top word
	localparam logic [63:0] EXT_Y = {16'h00ff, 16'hff00, 16'hffff, 16'h0000};
	localparam logic [63:0] EXT_U = {16'h00ff, 16'h00ff, 16'hffff, 16'h0000};
	localparam logic [63:0] EXT_V = {16'h00ff, 16'hff00, 16'h0000, 16'hffff};

	logic CLOCK_50 = 1'b0;
	logic Resetn;
	logic Start;
	logic [DATA_W-1:0] sram_read_data = '0;
	logic [ADDR_W-1:0] sram_address;
	logic [DATA_W-1:0] sram_write_data;
	logic sram_we_n;
	logic Done;

	logic [DATA_W-1:0] sram_mem [0:2**ADDR_W-1];
	logic [ADDR_W-1:0] rd_addr_q = '0;
	integer seed = 32'h6a31b311;
	int mismatches;
	int protocol_errors;
	int timeouts = 0;

	always #4 CLOCK_50 = ~CLOCK_50;

	csc_top DUT (
		.CLOCK_50(CLOCK_50),
		.Resetn(Resetn),
		.Start(Start),
		.sram_read_data(sram_read_data),
		.sram_address(sram_address),
		.sram_write_data(sram_write_data),
		.sram_we_n(sram_we_n),
		.Done(Done)
	);

	csc_checker u_chk (
		.CLOCK_50(CLOCK_50),
		.Resetn(Resetn),
		.Start(Start),
		.sram_address(sram_address),
		.sram_read_data(sram_read_data),
		.sram_write_data(sram_write_data),
		.sram_we_n(sram_we_n),
		.Done(Done),
		.mismatches(mismatches),
		.protocol_errors(protocol_errors)
	);

	// SRAM with two-cycle read latency
	always @(posedge CLOCK_50) begin
		if (sram_we_n === 1'b0) begin
			sram_mem[sram_address] <= sram_write_data;
		end
		rd_addr_q <= sram_address;
		sram_read_data <= sram_mem[rd_addr_q];
	end

	task automatic fill_image();
		for (int a = 0; a < 2**ADDR_W; a++) begin
			sram_mem[a] = 16'(a ^ (a >> 7)) ^ 16'h5ac3;
		end
		for (int k = 0; k < NUM_PAIRS; k++) begin
			if (k < 4) begin
				sram_mem[Y_BASE + k] = EXT_Y[63 - 16 * k -: 16];
				sram_mem[U_BASE + k] = EXT_U[63 - 16 * k -: 16];
				sram_mem[V_BASE + k] = EXT_V[63 - 16 * k -: 16];
			end else begin
				sram_mem[Y_BASE + k] = 16'($random(seed));
				sram_mem[U_BASE + k] = 16'($random(seed));
				sram_mem[V_BASE + k] = 16'($random(seed));
			end
		end
	endtask

	task automatic wait_done(output bit seen);
		int cycles;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < DONE_TIMEOUT) begin
			@(negedge CLOCK_50);
			seen = (Done === 1'b1);
			cycles++;
		end
	endtask

	task automatic run_conversion(input int run, output bit ok);
		@(negedge CLOCK_50);
		Start = 1'b1;
		@(negedge CLOCK_50);
		Start = 1'b0;
		wait_done(ok);
		if (!ok) begin
			timeouts++;
			$display("ERROR: Done not seen within %0d cycles in run %0d", DONE_TIMEOUT, run);
		end
	endtask

	initial begin
		bit ok;
		Resetn = 1'b0;
		Start = 1'b0;
		fill_image();
		repeat (4) @(posedge CLOCK_50);
		@(negedge CLOCK_50);
		Resetn = 1'b1;
		repeat (10) @(negedge CLOCK_50); // Idle before Start
		run_conversion(1, ok);
		if (ok) begin
			repeat (5) @(negedge CLOCK_50);
			run_conversion(2, ok);
		end
		repeat (5) @(negedge CLOCK_50);
		$display("Errors: %0d mismatches, %0d protocol, %0d assertion, %0d timeouts",
			mismatches, protocol_errors, DUT.u_asserts.assert_errors, timeouts);
		if (mismatches + protocol_errors + DUT.u_asserts.assert_errors + timeouts == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* test/csc_asserts.sv */
// SRAM and Done protocol assertions
`timescale 1ns/10ps

module csc_asserts (
	input logic CLOCK_50,
	input logic Resetn,
	input logic Start,
	input logic [csc_pkg::ADDR_W-1:0] sram_address,
	input logic sram_we_n,
	input logic Done
);

	import csc_pkg::*;

	logic busy;
	int assert_errors = 0;

	always @(posedge CLOCK_50 or negedge Resetn) begin
		if (!Resetn) begin
			busy <= 1'b0;
		end else if (Done) begin
			busy <= 1'b0;
		end else if (Start) begin
			busy <= 1'b1;
		end
	end

	done_one_cycle: assert property (@(posedge CLOCK_50) disable iff (!Resetn) Done |=> !Done)
		else begin
			assert_errors++;
			$error("Done stayed high for more than one cycle");
		end

	no_idle_write: assert property (@(posedge CLOCK_50) disable iff (!Resetn) !busy |-> sram_we_n)
		else begin
			assert_errors++;
			$error("SRAM write while the converter was idle");
		end

	write_in_range: assert property (@(posedge CLOCK_50) disable iff (!Resetn)
		!sram_we_n |-> (sram_address >= RGB_BASE && sram_address < RGB_BASE + 3 * NUM_PAIRS))
		else begin
			assert_errors++;
			$error("SRAM write outside the RGB region");
		end

endmodule

bind csc_top csc_asserts u_asserts (
	.CLOCK_50(CLOCK_50),
	.Resetn(Resetn),
	.Start(Start),
	.sram_address(sram_address),
	.sram_we_n(sram_we_n),
	.Done(Done)
);

/* test/csc_checker.sv */
// Conversion checker
`timescale 1ns/10ps

module csc_checker (
	input logic CLOCK_50,
	input logic Resetn,
	input logic Start,
	input logic [csc_pkg::ADDR_W-1:0] sram_address,
	input logic [csc_pkg::DATA_W-1:0] sram_read_data,
	input logic [csc_pkg::DATA_W-1:0] sram_write_data,
	input logic sram_we_n,
	input logic Done,
	output int mismatches,
	output int protocol_errors
);

	import csc_pkg::*;

	localparam int NUM_WORDS = 3 * NUM_PAIRS;

	logic [ADDR_W-1:0] rd_addr_d1 = '1;
	logic [ADDR_W-1:0] rd_addr_d2 = '1;
	logic [DATA_W-1:0] img [3][NUM_PAIRS]; // Y, U, V words seen on the bus
	bit seen [3][NUM_PAIRS];
	logic [DATA_W-1:0] first_run [NUM_WORDS];
	bit written [NUM_WORDS];
	bit running;
	bit last_was_write;
	bit after_reset;
	int write_count = 0;
	int runs = 0;
	int clip_low = 0;
	int clip_high = 0;
	int n_mis = 0;
	int n_prot = 0;

	assign mismatches = n_mis;
	assign protocol_errors = n_prot;

	// Unclipped channel sum for ch 0 R, 1 G or 2 B
	function automatic int channel_sum(int y, int u, int v, int ch);
		int luma;
		luma = COEF_A * (y - Y_OFFSET);
		case (ch)
			0: return (luma + COEF_B * (v - C_OFFSET)) >>> CSC_SHIFT;
			1: return (luma - COEF_C * (u - C_OFFSET) - COEF_D * (v - C_OFFSET)) >>> CSC_SHIFT;
			default: return (luma + COEF_E * (u - C_OFFSET)) >>> CSC_SHIFT;
		endcase
	endfunction

	function automatic logic [7:0] clip_byte(int s);
		return (s < 0) ? 8'd0 : (s > 255) ? 8'd255 : 8'(s);
	endfunction

	function automatic int pix_byte(logic [DATA_W-1:0] w, int p);
		return p ? int'(w[7:0]) : int'(w[15:8]); // Even pixel in the high byte
	endfunction

	function automatic logic [DATA_W-1:0] ref_word(logic [DATA_W-1:0] yw,
			logic [DATA_W-1:0] uw, logic [DATA_W-1:0] vw, int pos);
		logic [7:0] c [2][3]; // Pixel, channel
		for (int p = 0; p < 2; p++) begin
			for (int ch = 0; ch < 3; ch++) begin
				c[p][ch] = clip_byte(channel_sum(pix_byte(yw, p), pix_byte(uw, p),
					pix_byte(vw, p), ch));
			end
		end
		case (pos)
			0: return {c[0][0], c[0][1]};
			1: return {c[0][2], c[1][0]};
			default: return {c[1][1], c[1][2]};
		endcase
	endfunction

	task automatic count_clips(int k);
		int s;
		for (int p = 0; p < 2; p++) begin
			for (int ch = 0; ch < 3; ch++) begin
				s = channel_sum(pix_byte(img[0][k], p), pix_byte(img[1][k], p),
					pix_byte(img[2][k], p), ch);
				clip_low += (s < 0);
				clip_high += (s > 255);
			end
		end
	endtask

	task automatic record_read(logic [ADDR_W-1:0] a, logic [DATA_W-1:0] d);
		int k;
		logic [ADDR_W-1:0] base [3];
		base[0] = Y_BASE;
		base[1] = U_BASE;
		base[2] = V_BASE;
		for (int r = 0; r < 3; r++) begin
			k = int'(a) - int'(base[r]);
			if (k >= 0 && k < NUM_PAIRS && !$isunknown(d)) begin
				img[r][k] = d;
				seen[r][k] = 1'b1;
			end
		end
	endtask

	task automatic check_write(logic [ADDR_W-1:0] a, logic [DATA_W-1:0] d);
		int off;
		int k;
		logic [DATA_W-1:0] exp;
		off = int'(a) - int'(RGB_BASE);
		k = off / 3;
		if (!running) begin
			n_prot++;
			$display("ERROR: write to address %h while no conversion was running", a);
		end
		if (off < 0 || off >= NUM_WORDS) begin
			n_prot++;
			$display("ERROR: write to address %h outside the RGB region", a);
			return;
		end
		if (written[off]) begin
			n_prot++;
			$display("ERROR: address %h written twice in run %0d", a, runs + 1);
		end
		written[off] = 1'b1;
		write_count++;
		if (!(seen[0][k] && seen[1][k] && seen[2][k])) begin
			n_prot++;
			$display("ERROR: pair %0d written before its Y, U and V words were read", k);
			return;
		end
		exp = ref_word(img[0][k], img[1][k], img[2][k], off % 3);
		if (d !== exp) begin
			n_mis++;
			$display("mismatch rgb_word run %0d pair %0d word %0d: expected %h, actual %h",
				runs + 1, k, off % 3, exp, d);
		end
		if (runs == 0) begin
			first_run[off] = exp;
		end else if (d !== first_run[off]) begin
			n_mis++;
			$display("mismatch repeat_run pair %0d word %0d: expected %h, actual %h",
				k, off % 3, first_run[off], d);
		end
		if (off % 3 == 0) begin
			count_clips(k);
		end
	endtask

	task automatic end_of_run();
		if (!running) begin
			n_prot++;
			$display("ERROR: Done high while no conversion was running");
			return;
		end
		if (!last_was_write) begin
			n_prot++;
			$display("ERROR: Done in run %0d did not follow the last write", runs + 1);
		end
		if (write_count != NUM_WORDS) begin
			n_prot++;
			$display("ERROR: run %0d made %0d writes, %0d expected", runs + 1, write_count,
				NUM_WORDS);
		end
		if (clip_low == 0 || clip_high == 0) begin
			n_prot++;
			$display("ERROR: image did not drive any channel to both clip limits");
		end
		runs++;
		write_count = 0;
		clip_low = 0;
		clip_high = 0;
		running = 1'b0;
		foreach (written[i]) written[i] = 1'b0;
		foreach (seen[r, k]) seen[r][k] = 1'b0;
	endtask

	always @(posedge CLOCK_50 or negedge Resetn) begin
		if (!Resetn) begin
			rd_addr_d1 <= '1;
			rd_addr_d2 <= '1;
			running = 1'b0;
			last_was_write = 1'b0;
			after_reset = 1'b1;
		end else begin
			// Read data is on the bus two edges after its address
			rd_addr_d1 <= sram_address;
			rd_addr_d2 <= rd_addr_d1;
			record_read(rd_addr_d2, sram_read_data);
			if (after_reset && sram_address !== '0) begin
				n_mis++;
				$display("mismatch reset_address: expected %h, actual %h", 18'd0, sram_address);
			end
			after_reset = 1'b0;
			if ($isunknown({sram_we_n, Done})) begin
				n_prot++;
				$display("ERROR: sram_we_n or Done is unknown");
			end
			if (sram_we_n === 1'b0) begin
				check_write(sram_address, sram_write_data);
			end
			if (Done === 1'b1) begin
				end_of_run();
			end
			if (!running && Start === 1'b1) begin
				running = 1'b1; // Sampled in idle only
			end
			last_was_write = (sram_we_n === 1'b0);
		end
	end

endmodule

/* hdl/csc_top.sv */
// YUV to RGB converter top
`timescale 1ns/10ps

module csc_top (
	input logic CLOCK_50,
	input logic Resetn,
	input logic Start,
	input logic [csc_pkg::DATA_W-1:0] sram_read_data,
	output logic [csc_pkg::ADDR_W-1:0] sram_address,
	output logic [csc_pkg::DATA_W-1:0] sram_write_data,
	output logic sram_we_n,
	output logic Done
);

	import csc_pkg::*;

	phase_t phase;
	logic step;
	word_sel_t word_sel;
	sum_t r_sum;
	sum_t g_sum;
	sum_t b_sum;
	logic pixel_valid;

	pair_sequencer u_seq (
		.CLOCK_50(CLOCK_50),
		.Resetn(Resetn),
		.Start(Start),
		.phase(phase),
		.step(step),
		.word_sel(word_sel),
		.sram_address(sram_address),
		.sram_we_n(sram_we_n),
		.Done(Done)
	);

	csc_datapath u_dp (
		.CLOCK_50(CLOCK_50),
		.Resetn(Resetn),
		.step(step),
		.phase(phase),
		.sram_read_data(sram_read_data),
		.r_sum(r_sum),
		.g_sum(g_sum),
		.b_sum(b_sum),
		.pixel_valid(pixel_valid)
	);

	rgb_packer u_pack (
		.CLOCK_50(CLOCK_50),
		.Resetn(Resetn),
		.pixel_valid(pixel_valid),
		.r_sum(r_sum),
		.g_sum(g_sum),
		.b_sum(b_sum),
		.word_sel(word_sel),
		.sram_write_data(sram_write_data)
	);

endmodule

/* hdl/rgb_packer.sv */
// RGB clip and pack
`timescale 1ns/10ps

module rgb_packer (
	input logic CLOCK_50,
	input logic Resetn,
	input logic pixel_valid,
	input csc_pkg::sum_t r_sum,
	input csc_pkg::sum_t g_sum,
	input csc_pkg::sum_t b_sum,
	input csc_pkg::word_sel_t word_sel,
	output logic [csc_pkg::DATA_W-1:0] sram_write_data
);

	import csc_pkg::*;

	logic odd_next;
	logic [7:0] r0, g0, b0;
	logic [7:0] r1, g1, b1;

	function automatic logic [7:0] clip(input sum_t s);
		if (s[31]) begin
			return 8'd0;
		end else if (|s[30:8]) begin
			return 8'd255;
		end
		return s[7:0];
	endfunction

	always_ff @(posedge CLOCK_50 or negedge Resetn) begin
		if (!Resetn) begin
			odd_next <= 1'b0;
		end else if (pixel_valid) begin
			odd_next <= ~odd_next; // Pixels arrive even, odd, even, ...
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (pixel_valid && !odd_next) begin
			r0 <= clip(r_sum);
			g0 <= clip(g_sum);
			b0 <= clip(b_sum);
		end
		if (pixel_valid && odd_next) begin
			r1 <= clip(r_sum);
			g1 <= clip(g_sum);
			b1 <= clip(b_sum);
		end
	end

	always_comb begin
		case (word_sel)
			COMB_PAIR: sram_write_data = {b0, r1};
			ODD_PAIR: sram_write_data = {g1, b1};
			default: sram_write_data = {r0, g0};
		endcase
	end

endmodule

/* hdl/csc_datapath.sv */
// Colour matrix datapath
`timescale 1ns/10ps

module csc_datapath (
	input logic CLOCK_50,
	input logic Resetn,
	input logic step,
	input csc_pkg::phase_t phase,
	input logic [csc_pkg::DATA_W-1:0] sram_read_data,
	output csc_pkg::sum_t r_sum,
	output csc_pkg::sum_t g_sum,
	output csc_pkg::sum_t b_sum,
	output logic pixel_valid
);

	import csc_pkg::*;

	logic [DATA_W-1:0] y_word;
	logic [DATA_W-1:0] u_word;
	logic [DATA_W-1:0] v_word;
	logic odd_pix;
	logic acc_step;
	logic [7:0] y_byte;
	logic [7:0] u_byte;
	logic [7:0] v_byte;
	sum_t y_off;
	sum_t u_off;
	sum_t v_off;
	sum_t m1_op;
	sum_t m1_coef;
	sum_t m2_coef;
	sum_t m1;
	sum_t m2;
	sum_t m3;

	assign odd_pix = (phase == MUL_ODD) || (phase == ACC_ODD);
	assign acc_step = (phase == ACC_EVEN) || (phase == ACC_ODD);

	// Even pixel in the high byte, odd pixel in the low byte
	assign y_byte = odd_pix ? y_word[7:0] : y_word[15:8];
	assign u_byte = odd_pix ? u_word[7:0] : u_word[15:8];
	assign v_byte = odd_pix ? v_word[7:0] : v_word[15:8];

	assign y_off = $signed({24'd0, y_byte}) - Y_OFFSET;
	assign u_off = $signed({24'd0, u_byte}) - C_OFFSET;
	assign v_off = $signed({24'd0, v_byte}) - C_OFFSET;

	// Luma and R/B chroma on MUL, G chroma on ACC
	always_comb begin
		if (acc_step) begin
			m1_op = u_off;
			m1_coef = COEF_C;
			m2_coef = COEF_D;
		end else begin
			m1_op = y_off;
			m1_coef = COEF_A;
			m2_coef = COEF_B;
		end
	end

	assign m1 = m1_op * m1_coef;
	assign m2 = v_off * m2_coef;
	assign m3 = u_off * COEF_E;

	always_ff @(posedge CLOCK_50) begin
		if (step) begin
			case (phase)
				LOAD_Y: y_word <= sram_read_data;
				LOAD_U: u_word <= sram_read_data;
				LOAD_V: v_word <= sram_read_data;
				MUL_EVEN, MUL_ODD: begin
					r_sum <= (m1 + m2) >>> CSC_SHIFT;
					g_sum <= m1; // Luma term, chroma follows
					b_sum <= (m1 + m3) >>> CSC_SHIFT;
				end
				ACC_EVEN, ACC_ODD: begin
					g_sum <= (g_sum - m1 - m2) >>> CSC_SHIFT;
				end
				default: ;
			endcase
		end
	end

	// All three sums final after the ACC step
	always_ff @(posedge CLOCK_50 or negedge Resetn) begin
		if (!Resetn) begin
			pixel_valid <= 1'b0;
		end else begin
			pixel_valid <= step && acc_step;
		end
	end

endmodule

/* hdl/pair_sequencer.sv */
// Pixel pair sequencer
`timescale 1ns/10ps

module pair_sequencer (
	input logic CLOCK_50,
	input logic Resetn,
	input logic Start,
	output csc_pkg::phase_t phase,
	output logic step,
	output csc_pkg::word_sel_t word_sel,
	output logic [csc_pkg::ADDR_W-1:0] sram_address,
	output logic sram_we_n,
	output logic Done
);

	import csc_pkg::*;

	localparam int PAIR_CYCLES = 12;

	typedef enum logic [1:0] {
		S_IDLE,
		S_RUN,
		S_FLUSH
	} seq_state_t;

	seq_state_t state;
	logic [3:0] cycle_cnt;
	logic [ADDR_W-1:0] pair_idx;
	logic [ADDR_W-1:0] rgb_cnt;
	logic last_pair;
	word_sel_t next_sel;

	assign last_pair = (pair_idx == ADDR_W'(NUM_PAIRS - 1));

	// Datapath strobes, acting at the end of the current cycle
	assign step = (state == S_RUN) && (cycle_cnt >= 4'd3) && (cycle_cnt <= 4'd9);

	always_comb begin
		case (cycle_cnt)
			4'd4: phase = LOAD_U;
			4'd5: phase = LOAD_V;
			4'd6: phase = MUL_EVEN;
			4'd7: phase = ACC_EVEN;
			4'd8: phase = MUL_ODD;
			4'd9: phase = ACC_ODD;
			default: phase = LOAD_Y;
		endcase
	end

	always_comb begin
		case (cycle_cnt)
			4'd8: next_sel = EVEN_PAIR; // Even pixel just stored
			4'd10: next_sel = COMB_PAIR;
			default: next_sel = ODD_PAIR;
		endcase
	end

	always_ff @(posedge CLOCK_50 or negedge Resetn) begin
		if (!Resetn) begin
			state <= S_IDLE;
			cycle_cnt <= 4'd0;
			pair_idx <= '0;
			rgb_cnt <= '0;
			sram_address <= '0;
			sram_we_n <= 1'b1;
			word_sel <= EVEN_PAIR;
			Done <= 1'b0;
		end else begin
			Done <= 1'b0;
			sram_we_n <= 1'b1;
			case (state)
				S_IDLE: begin
					cycle_cnt <= 4'd0;
					if (Start) begin
						state <= S_RUN;
					end
				end

				S_RUN: begin
					case (cycle_cnt)
						4'd0: sram_address <= Y_BASE + pair_idx; // Data back in cycle 3
						4'd1: sram_address <= U_BASE + pair_idx;
						4'd2: sram_address <= V_BASE + pair_idx;
						4'd8, 4'd10, 4'd11: begin
							sram_address <= RGB_BASE + rgb_cnt;
							sram_we_n <= 1'b0;
							word_sel <= next_sel;
							rgb_cnt <= rgb_cnt + 1'b1;
						end
						default: ;
					endcase

					if (cycle_cnt == 4'(PAIR_CYCLES - 1)) begin
						cycle_cnt <= 4'd0;
						if (last_pair) begin
							pair_idx <= '0;
							state <= S_FLUSH; // Last ODD_PAIR write still pending
						end else begin
							pair_idx <= pair_idx + 1'b1;
						end
					end else begin
						cycle_cnt <= cycle_cnt + 1'b1;
					end
				end

				S_FLUSH: begin
					rgb_cnt <= '0;
					Done <= 1'b1;
					state <= S_IDLE;
				end

				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

/* hdl/csc_pkg.sv */
// Colour space converter definitions
package csc_pkg;

	// SRAM port
	localparam int ADDR_W = 18;
	localparam int DATA_W = 16;

	// Memory map, one word per pixel pair in each YUV region
	localparam logic [ADDR_W-1:0] Y_BASE = 18'd0;
	localparam logic [ADDR_W-1:0] U_BASE = 18'd38400;
	localparam logic [ADDR_W-1:0] V_BASE = 18'd57600;
	localparam logic [ADDR_W-1:0] RGB_BASE = 18'd146944; // Three words per pair

	localparam int NUM_PAIRS = 48;

	// Signed channel sum
	typedef logic signed [31:0] sum_t;

	// Colour matrix in 16.16 fixed point
	localparam sum_t COEF_A = 32'sd76284; // Luma, all channels
	localparam sum_t COEF_B = 32'sd104595; // V to R
	localparam sum_t COEF_C = 32'sd25624; // U to G
	localparam sum_t COEF_D = 32'sd53281; // V to G
	localparam sum_t COEF_E = 32'sd132251; // U to B

	localparam sum_t Y_OFFSET = 32'sd16;
	localparam sum_t C_OFFSET = 32'sd128;

	localparam int CSC_SHIFT = 16;

	// Datapath steps within one pair
	typedef enum logic [2:0] {
		LOAD_Y,
		LOAD_U,
		LOAD_V,
		MUL_EVEN,
		ACC_EVEN,
		MUL_ODD,
		ACC_ODD
	} phase_t;

	// RGB write words of one pair
	typedef enum logic [1:0] {
		EVEN_PAIR, // {R0,G0}
		COMB_PAIR, // {B0,R1}
		ODD_PAIR // {G1,B1}
	} word_sel_t;

endpackage
